/* project.f */
trdb_pkg.sv
trdb_branch_map.sv
trdb_priority.sv
trdb_packet_emitter.sv
trdb_encapsulator.sv
trdb_top.sv
tb_trdb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_trdb_top -Mdir obj_dir
./obj_dir/Vtb_trdb_top > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tb_trdb_top.sv */
module tb_trdb_top;
    timeunit 1ns;
    timeprecision 1ps;

    import trdb_pkg::*;

    localparam int LATENCY   = 4;   // negedges from drive to packet_valid_o
    localparam int DRAIN_MAX = 20;  // cycles allowed for the last packets
    localparam logic [PRIV_LEN-1:0] PRIV_M = 2'b11;  // machine mode throughout

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    logic                  iretire_i;
    logic [XLEN-1:0]       iaddr_i;
    logic [PRIV_LEN-1:0]   priv_i;
    logic                  is_branch_i;
    logic                  is_branch_taken_i;
    logic                  exception_i;
    logic                  interrupt_i;
    logic [CAUSE_LEN-1:0]  cause_i;
    logic [XLEN-1:0]       tval_i;
    logic                  updiscon_i;
    logic                  packet_valid_o;
    logic [PACKET_LEN-1:0] packet_o;

    // expected packets, oldest first
    logic [PACKET_LEN-1:0] exp_pkt_q[$];
    trdb_format_e          exp_fmt_q[$];
    int                    exp_bits_q[$];  // payload field bits
    int                    exp_cyc_q[$];   // arrival negedge
    logic [SEQ_W-1:0]      exp_seq;

    string test_name;
    int    cyc = 0;        // negedge count
    int    drive_cyc = 0;  // cyc at the last retirement drive
    int    rx_cnt = 0;
    int    err_cnt = 0;
    int    test_err = 0;   // err_cnt when the test began
    int    pass_cnt = 0;
    int    fail_cnt = 0;

    always #4 clk_i = ~clk_i;  // 8 ns period

    trdb_top dut0 (
        .clk_i, .rst_i, .iretire_i, .iaddr_i, .priv_i, .is_branch_i, .is_branch_taken_i,
        .exception_i, .interrupt_i, .cause_i, .tval_i, .updiscon_i,
        .packet_valid_o, .packet_o
    );

    // reference payload, fields shifted in from the left
    function automatic logic [PACKET_LEN-1:0] build_packet(
        input trdb_format_e fmt, input trdb_f_sync_subformat_e sf, input logic branch,
        input logic [CAUSE_LEN-1:0] cause, input logic intr, input logic [XLEN-1:0] addr,
        input logic [XLEN-1:0] tval, input logic [BCNT_LEN-1:0] branches,
        input logic [BMAP_LEN-1:0] map, input logic with_addr, input logic [SEQ_W-1:0] seq,
        output int nbits);
        logic [PAYLOAD_LEN-1:0] pl;
        logic [PLEN_W-1:0]      nbytes;
        pl    = PAYLOAD_LEN'(fmt);
        nbits = 2;
        case (fmt)
            F_SYNC: begin
                pl    = (pl << 3) | PAYLOAD_LEN'({sf, branch});
                pl    = (pl << PRIV_LEN) | PAYLOAD_LEN'(PRIV_M);
                nbits = nbits + 3 + PRIV_LEN;
                if (sf == SF_TRAP) begin
                    pl    = (pl << (CAUSE_LEN + 1)) | PAYLOAD_LEN'({cause, intr});
                    nbits = nbits + CAUSE_LEN + 1;
                end
                pl    = (pl << XLEN) | PAYLOAD_LEN'(addr);
                nbits = nbits + XLEN;
                if (sf == SF_TRAP) begin
                    pl    = (pl << XLEN) | PAYLOAD_LEN'(tval);  // tval last
                    nbits = nbits + XLEN;
                end
            end
            F_ADDR_ONLY: begin
                pl    = (pl << (XLEN + 1)) | PAYLOAD_LEN'({addr, 1'b1});  // updiscon bit
                nbits = nbits + XLEN + 1;
            end
            default: begin
                // format 1, count reads 0 for a full map
                pl    = (pl << BCNT_LEN) | PAYLOAD_LEN'(with_addr ? branches : BCNT_LEN'(0));
                pl    = (pl << BMAP_LEN) | PAYLOAD_LEN'(map);
                nbits = nbits + BCNT_LEN + BMAP_LEN;
                if (with_addr) begin
                    pl    = (pl << XLEN) | PAYLOAD_LEN'(addr);
                    nbits = nbits + XLEN;
                end
            end
        endcase
        nbytes = PLEN_W'((nbits + 7) / 8);  // whole bytes
        return {seq, nbytes, pl};
    endfunction

    task automatic compare_format(input trdb_format_e exp, input trdb_format_e act);
        if (act !== exp) begin
            $display("MISMATCH %s format expected %s actual %s", test_name, exp.name(),
                     act.name());
            err_cnt++;
        end
    endtask

    task automatic compare_length(input logic [PLEN_W-1:0] exp, input logic [PLEN_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s length expected %0d actual %0d", test_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_packet(input logic [PACKET_LEN-1:0] exp,
                                  input logic [PACKET_LEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s packet expected %h actual %h", test_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_arrival(input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s arrival cycle expected %0d actual %0d", test_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_packet();
        logic [PACKET_LEN-1:0] exp;
        trdb_format_e          fmt_act;
        int                    bits;
        rx_cnt++;
        if (exp_pkt_q.size() == 0) begin
            $display("ERROR %s: packet %h arrived when none was expected", test_name, packet_o);
            err_cnt++;
            return;
        end
        exp     = exp_pkt_q.pop_front();
        bits    = exp_bits_q.pop_front();
        fmt_act = trdb_format_e'(2'(packet_o >> (bits - 2)));  // top two field bits
        compare_format(exp_fmt_q.pop_front(), fmt_act);
        compare_length(exp[PAYLOAD_LEN +: PLEN_W], packet_o[PAYLOAD_LEN +: PLEN_W]);
        compare_packet(exp, packet_o);
        compare_arrival(exp_cyc_q.pop_front(), cyc);
    endtask

    // outputs settle well before the negedge
    always @(negedge clk_i) begin
        cyc = cyc + 1;
        if (packet_valid_o === 1'b1) begin
            check_packet();
        end
    end

    task automatic apply_reset();
        int k;
        rst_i             <= 1'b1;
        iretire_i         <= 1'b0;
        iaddr_i           <= '0;
        priv_i            <= PRIV_M;
        is_branch_i       <= 1'b0;
        is_branch_taken_i <= 1'b0;
        exception_i       <= 1'b0;
        interrupt_i       <= 1'b0;
        cause_i           <= '0;
        tval_i            <= '0;
        updiscon_i        <= 1'b0;
        for (k = 0; k < 4; k++) begin
            @(posedge clk_i);
        end
        rst_i <= 1'b0;
    endtask

    task automatic drive_idle(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(posedge clk_i);
            iretire_i   <= 1'b0;
            is_branch_i <= 1'b0;
            exception_i <= 1'b0;
            interrupt_i <= 1'b0;
            updiscon_i  <= 1'b0;
        end
    endtask

    // one retirement in the next cycle
    task automatic drive_retire(input logic [XLEN-1:0] addr, input logic is_br,
                                input logic taken, input logic upd, input logic exc,
                                input logic [CAUSE_LEN-1:0] cause, input logic intr,
                                input logic [XLEN-1:0] tval);
        @(posedge clk_i);
        iretire_i         <= 1'b1;
        iaddr_i           <= addr;
        priv_i            <= PRIV_M;
        is_branch_i       <= is_br;
        is_branch_taken_i <= taken;
        updiscon_i        <= upd;
        exception_i       <= exc;
        cause_i           <= cause;
        interrupt_i       <= intr;
        tval_i            <= tval;
        drive_cyc = cyc;
    endtask

    // packet due from the retirement just driven
    task automatic expect_packet(input trdb_format_e fmt, input trdb_f_sync_subformat_e sf,
                                 input logic branch, input logic [CAUSE_LEN-1:0] cause,
                                 input logic intr, input logic [XLEN-1:0] addr,
                                 input logic [XLEN-1:0] tval, input logic [BCNT_LEN-1:0] branches,
                                 input logic [BMAP_LEN-1:0] map, input logic with_addr);
        int bits;
        exp_pkt_q.push_back(build_packet(fmt, sf, branch, cause, intr, addr, tval, branches,
                                         map, with_addr, exp_seq, bits));
        exp_fmt_q.push_back(fmt);
        exp_bits_q.push_back(bits);
        exp_cyc_q.push_back(drive_cyc + LATENCY);
        exp_seq = exp_seq + 1'b1;  // wraps mod 8
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = err_cnt;
        exp_seq   = '0;
        apply_reset();
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        drive_idle(1);
        while (exp_pkt_q.size() != 0 && waited < DRAIN_MAX) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_pkt_q.size() != 0) begin
            $display("ERROR %s: timed out with %0d expected packets still missing", test_name,
                     exp_pkt_q.size());
            err_cnt++;
            exp_pkt_q.delete();
            exp_fmt_q.delete();
            exp_bits_q.delete();
            exp_cyc_q.delete();
        end
        if (err_cnt == test_err) begin
            pass_cnt++;
            $display("test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", test_name, err_cnt - test_err);
        end
    endtask

    task automatic test_reset_start();
        logic [XLEN-1:0] a;
        int              rx_before;
        start_test("reset_start");
        rx_before = rx_cnt;
        drive_idle(10);
        if (rx_cnt != rx_before) begin
            $display("ERROR %s: packet_valid_o went high with no retirement", test_name);
            err_cnt++;
        end
        a = $urandom();
        drive_retire(a, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, a, '0, '0, '0, 1'b0);
        end_test();
    endtask

    task automatic test_updiscon();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] t;
        start_test("updiscon");
        a = $urandom();
        drive_retire(a, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, a, '0, '0, '0, 1'b0);
        drive_retire(a + 4, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0);   // taken
        drive_retire(a + 8, 1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);   // not taken
        drive_retire(a + 12, 1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);  // not taken
        drive_retire(a + 16, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0);  // taken
        drive_retire(a + 20, 1'b0, 1'b0, 1'b1, 1'b0, '0, 1'b0, '0);  // jalr
        // jump target, itself another indirect jump
        t = $urandom();
        drive_retire(t, 1'b0, 1'b0, 1'b1, 1'b0, '0, 1'b0, '0);
        expect_packet(F_DIFF_DELTA, SF_START, 1'b1, '0, 1'b0, t, '0, 5'd4, 31'b0110, 1'b1);
        t = $urandom();
        drive_retire(t, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);  // no branches since
        expect_packet(F_ADDR_ONLY, SF_START, 1'b1, '0, 1'b0, t, '0, '0, '0, 1'b0);
        end_test();
    endtask

    task automatic test_full_map();
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     t;
        logic [BMAP_LEN-1:0] map;
        logic                tk;
        int                  i;
        start_test("full_map");
        a = $urandom();
        drive_retire(a, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, a, '0, '0, '0, 1'b0);
        map = '0;
        for (i = 0; i < BMAP_LEN; i++) begin
            tk     = 1'($urandom());
            map[i] = ~tk;  // set bit means not taken
            drive_retire(a + 32'(4 * (i + 1)), 1'b1, tk, 1'b0, 1'b0, '0, 1'b0, '0);
        end
        expect_packet(F_DIFF_DELTA, SF_START, 1'b1, '0, 1'b0, '0, '0, BCNT_LEN'(BMAP_LEN),
                      map, 1'b0);
        // map starts over at index 0
        drive_retire(a + 200, 1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        drive_retire(a + 204, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
        drive_retire(a + 208, 1'b0, 1'b0, 1'b1, 1'b0, '0, 1'b0, '0);
        t = $urandom();
        drive_retire(t, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        expect_packet(F_DIFF_DELTA, SF_START, 1'b1, '0, 1'b0, t, '0, 5'd2, 31'b01, 1'b1);
        end_test();
    endtask

    task automatic test_trap();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] h;
        logic [XLEN-1:0] tv;
        start_test("trap");
        a = $urandom();
        drive_retire(a, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, a, '0, '0, '0, 1'b0);
        drive_retire(a + 4, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        tv = $urandom();
        drive_retire(a + 8, 1'b0, 1'b0, 1'b0, 1'b1, 5'd13, 1'b0, tv);  // load page fault
        expect_packet(F_SYNC, SF_TRAP, 1'b1, 5'd13, 1'b0, a + 8, tv, '0, '0, 1'b0);
        h = $urandom();
        drive_retire(h, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);  // handler entry
        expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, h, '0, '0, '0, 1'b0);
        drive_retire(h + 4, 1'b0, 1'b0, 1'b0, 1'b1, 5'd7, 1'b1, '0);  // timer interrupt
        expect_packet(F_SYNC, SF_TRAP, 1'b1, 5'd7, 1'b1, h + 4, '0, '0, '0, 1'b0);
        h = $urandom();
        drive_retire(h, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, h, '0, '0, '0, 1'b0);
        end_test();
    endtask

    task automatic test_resync_seq();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] tv;
        int              i;
        start_test("resync_seq");
        a = $urandom();
        drive_retire(a, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, a, '0, '0, '0, 1'b0);
        for (i = 1; i <= RESYNC_MAX + 4; i++) begin
            // forced start lands on a taken branch
            drive_retire(a + 32'(4 * i), (i == RESYNC_MAX), (i == RESYNC_MAX), 1'b0, 1'b0,
                         '0, 1'b0, '0);
            if (i == RESYNC_MAX) begin
                expect_packet(F_SYNC, SF_START, 1'b0, '0, 1'b0, a + 32'(4 * i), '0, '0, '0,
                              1'b0);
            end
        end
        // trap and start alternate, one packet every cycle
        for (i = 0; i < 10; i++) begin
            b = $urandom();
            if (i % 2 == 0) begin
                tv = $urandom();
                drive_retire(b, 1'b0, 1'b0, 1'b0, 1'b1, 5'd2, 1'b0, tv);  // illegal instr
                expect_packet(F_SYNC, SF_TRAP, 1'b1, 5'd2, 1'b0, b, tv, '0, '0, 1'b0);
            end else begin
                drive_retire(b, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
                expect_packet(F_SYNC, SF_START, 1'b1, '0, 1'b0, b, '0, '0, '0, 1'b0);
            end
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h5448));
        test_reset_start();
        test_updiscon();
        test_full_map();
        test_trap();
        test_resync_seq();
        $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* trdb_top.sv */
module trdb_top (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             iretire_i,
    input  logic [trdb_pkg::XLEN-1:0]        iaddr_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]    priv_i,
    input  logic                             is_branch_i,
    input  logic                             is_branch_taken_i,
    input  logic                             exception_i,
    input  logic                             interrupt_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0]   cause_i,
    input  logic [trdb_pkg::XLEN-1:0]        tval_i,
    input  logic                             updiscon_i,  // uninferable jump
    output logic                             packet_valid_o,
    output logic [trdb_pkg::PACKET_LEN-1:0]  packet_o
);

    import trdb_pkg::*;

    // branch map loop
    logic                bm_add, bm_taken, bm_flush;
    logic [BCNT_LEN-1:0] bm_branches;
    logic [BMAP_LEN-1:0] bm_map;

    // priority to emitter
    logic                   pr_valid, pr_branch, pr_interrupt, pr_with_addr;
    trdb_format_e           pr_format;
    trdb_f_sync_subformat_e pr_subformat;
    logic [PRIV_LEN-1:0]    pr_priv;
    logic [CAUSE_LEN-1:0]   pr_cause;
    logic [XLEN-1:0]        pr_addr, pr_tval;
    logic [BCNT_LEN-1:0]    pr_branches;
    logic [BMAP_LEN-1:0]    pr_map;

    // emitter to encapsulator
    logic                   em_valid;
    logic [PAYLOAD_LEN-1:0] em_payload;
    logic [PLEN_W-1:0]      em_length;

    trdb_branch_map i_branch_map (
        .clk_i, .rst_i,
        .add_i (bm_add), .taken_i (bm_taken), .flush_i (bm_flush),
        .branches_o (bm_branches), .branch_map_o (bm_map)
    );

    trdb_priority i_priority (
        .clk_i, .rst_i, .iretire_i, .iaddr_i, .priv_i, .is_branch_i, .is_branch_taken_i,
        .exception_i, .interrupt_i, .cause_i, .tval_i, .updiscon_i,
        .branches_i (bm_branches), .branch_map_i (bm_map),
        .bm_add_o (bm_add), .bm_taken_o (bm_taken), .bm_flush_o (bm_flush),
        .emit_valid_o (pr_valid), .format_o (pr_format), .subformat_o (pr_subformat),
        .branch_o (pr_branch), .priv_o (pr_priv), .cause_o (pr_cause),
        .interrupt_o (pr_interrupt), .addr_o (pr_addr), .tval_o (pr_tval),
        .branches_o (pr_branches), .branch_map_o (pr_map), .with_addr_o (pr_with_addr)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i, .rst_i, .valid_i (pr_valid),
        .packet_format_i (pr_format), .packet_f_sync_subformat_i (pr_subformat),
        .branch_i (pr_branch), .priv_i (pr_priv), .cause_i (pr_cause),
        .interrupt_i (pr_interrupt), .iaddr_i (pr_addr), .tval_i (pr_tval),
        .branches_i (pr_branches), .branch_map_i (pr_map), .with_addr_i (pr_with_addr),
        .packet_payload_o (em_payload), .payload_length_o (em_length),
        .packet_valid_o (em_valid)
    );

    trdb_encapsulator i_encapsulator (
        .clk_i, .rst_i, .valid_i (em_valid),
        .payload_i (em_payload), .length_i (em_length),
        .packet_o, .packet_valid_o
    );

endmodule

/* trdb_encapsulator.sv */
module trdb_encapsulator (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              valid_i,
    input  logic [trdb_pkg::PAYLOAD_LEN-1:0]  payload_i,
    input  logic [trdb_pkg::PLEN_W-1:0]       length_i,
    output logic [trdb_pkg::PACKET_LEN-1:0]   packet_o,  // header in top byte
    output logic                              packet_valid_o
);

    import trdb_pkg::*;

    logic [SEQ_W-1:0]   seq_q;   // wraps mod 8
    logic [HDR_LEN-1:0] header;

    // seq in 7:5, length in 4:0
    assign header = {seq_q, length_i};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            seq_q          <= '0;
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= valid_i;
            if (valid_i) begin
                seq_q <= seq_q + 1'b1;  // one step per packet
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            packet_o <= {header, payload_i};
        end
    end

endmodule

/* trdb_packet_emitter.sv */
module trdb_packet_emitter (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              valid_i,
    input  trdb_pkg::trdb_format_e            packet_format_i,
    input  trdb_pkg::trdb_f_sync_subformat_e  packet_f_sync_subformat_i,
    input  logic                              branch_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]     priv_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0]    cause_i,
    input  logic                              interrupt_i,
    input  logic [trdb_pkg::XLEN-1:0]         iaddr_i,
    input  logic [trdb_pkg::XLEN-1:0]         tval_i,
    input  logic [trdb_pkg::BCNT_LEN-1:0]     branches_i,
    input  logic [trdb_pkg::BMAP_LEN-1:0]     branch_map_i,
    input  logic                              with_addr_i,
    output logic [trdb_pkg::PAYLOAD_LEN-1:0]  packet_payload_o,  // right aligned
    output logic [trdb_pkg::PLEN_W-1:0]       payload_length_o,  // bytes
    output logic                              packet_valid_o
);

    import trdb_pkg::*;

    logic [PAYLOAD_LEN-1:0] payload_d;
    logic [PLEN_W-1:0]      length_d;

    // last listed field lands at bit 0
    always_comb begin
        payload_d = '0;
        length_d  = '0;  // zero flags an unsupported format
        case (packet_format_i)
            F_SYNC: begin
                case (packet_f_sync_subformat_i)
                    SF_START: begin
                        payload_d = PAYLOAD_LEN'({packet_format_i, packet_f_sync_subformat_i,
                                                  branch_i, priv_i, iaddr_i});
                        length_d  = PLEN_W'(START_BYTES);
                    end
                    SF_TRAP: begin
                        payload_d = PAYLOAD_LEN'({packet_format_i, packet_f_sync_subformat_i,
                                                  branch_i, priv_i, cause_i, interrupt_i,
                                                  iaddr_i, tval_i});
                        length_d  = PLEN_W'(TRAP_BYTES);
                    end
                    default: begin
                        // context and support not built
                        payload_d = '0;
                    end
                endcase
            end
            F_ADDR_ONLY: begin
                // only sent after an uninferable jump
                payload_d = PAYLOAD_LEN'({packet_format_i, iaddr_i, 1'b1});
                length_d  = PLEN_W'(ADDR_ONLY_BYTES);
            end
            F_DIFF_DELTA: begin
                if (with_addr_i) begin
                    payload_d = PAYLOAD_LEN'({packet_format_i, branches_i, branch_map_i,
                                              iaddr_i});
                    length_d  = PLEN_W'(DIFF_ADDR_BYTES);
                end else begin
                    // full map, branches field reads 0
                    payload_d = PAYLOAD_LEN'({packet_format_i, {BCNT_LEN{1'b0}},
                                              branch_map_i});
                    length_d  = PLEN_W'(DIFF_BYTES);
                end
            end
            default: begin
                payload_d = '0;  // format 0 left out
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= valid_i;
        end
    end

    // payload regs, no reset
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            packet_payload_o <= payload_d;
            payload_length_o <= length_d;
        end
    end

    // priority only hands over formats the case knows
    a_len_nonzero: assert property (
        @(posedge clk_i) disable iff (rst_i)
        packet_valid_o |-> (payload_length_o != '0)
    );

endmodule

/* trdb_priority.sv */
module trdb_priority (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   iretire_i,
    input  logic [trdb_pkg::XLEN-1:0]              iaddr_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]          priv_i,
    input  logic                                   is_branch_i,
    input  logic                                   is_branch_taken_i,
    input  logic                                   exception_i,
    input  logic                                   interrupt_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0]         cause_i,
    input  logic [trdb_pkg::XLEN-1:0]              tval_i,
    input  logic                                   updiscon_i,
    input  logic [trdb_pkg::BCNT_LEN-1:0]          branches_i,   // incl. current branch
    input  logic [trdb_pkg::BMAP_LEN-1:0]          branch_map_i,
    output logic                                   bm_add_o,
    output logic                                   bm_taken_o,
    output logic                                   bm_flush_o,
    output logic                                   emit_valid_o,
    output trdb_pkg::trdb_format_e                 format_o,
    output trdb_pkg::trdb_f_sync_subformat_e       subformat_o,
    output logic                                   branch_o,
    output logic [trdb_pkg::PRIV_LEN-1:0]          priv_o,
    output logic [trdb_pkg::CAUSE_LEN-1:0]         cause_o,
    output logic                                   interrupt_o,
    output logic [trdb_pkg::XLEN-1:0]              addr_o,
    output logic [trdb_pkg::XLEN-1:0]              tval_o,
    output logic [trdb_pkg::BCNT_LEN-1:0]          branches_o,
    output logic [trdb_pkg::BMAP_LEN-1:0]          branch_map_o,
    output logic                                   with_addr_o   // format 1 form
);

    import trdb_pkg::*;

    logic                   first_q;       // no retirement since reset
    logic                   after_trap_q;  // last packet was a trap
    logic                   updiscon_q;    // previous instr was uninferable jump
    logic [RESYNC_W-1:0]    resync_cnt_q;  // retirements since last format 3
    logic                   resync_due;
    logic                   emit_d;
    logic                   with_addr_d;
    trdb_format_e           format_d;
    trdb_f_sync_subformat_e subformat_d;

    assign bm_add_o   = iretire_i & is_branch_i;
    assign bm_taken_o = is_branch_taken_i;
    assign bm_flush_o = emit_d;  // every packet empties the map

    // this retirement is the RESYNC_MAX-th after the last sync
    assign resync_due = (resync_cnt_q == RESYNC_W'(RESYNC_MAX - 1));

    // ordered format rules
    always_comb begin
        emit_d      = 1'b0;
        format_d    = F_SYNC;
        subformat_d = SF_START;
        with_addr_d = 1'b0;
        if (iretire_i) begin
            if (first_q || after_trap_q || resync_due) begin
                emit_d = 1'b1;  // start
            end else if (exception_i) begin
                emit_d      = 1'b1;
                subformat_d = SF_TRAP;
            end else if (updiscon_q) begin
                emit_d = 1'b1;
                if (branches_i != '0) begin
                    format_d    = F_DIFF_DELTA;
                    with_addr_d = 1'b1;
                end else begin
                    format_d = F_ADDR_ONLY;
                end
            end else if (branches_i == BCNT_LEN'(BMAP_LEN)) begin
                emit_d   = 1'b1;  // map full, no addr needed
                format_d = F_DIFF_DELTA;
            end
        end
    end

    // control state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            first_q      <= 1'b1;
            after_trap_q <= 1'b0;
            updiscon_q   <= 1'b0;
            resync_cnt_q <= '0;
            emit_valid_o <= 1'b0;
        end else begin
            emit_valid_o <= emit_d;
            if (iretire_i) begin
                first_q      <= 1'b0;
                after_trap_q <= emit_d && (format_d == F_SYNC) && (subformat_d == SF_TRAP);
                updiscon_q   <= updiscon_i;
                if (emit_d && (format_d == F_SYNC)) begin
                    resync_cnt_q <= '0;  // any format 3 restarts the count
                end else begin
                    resync_cnt_q <= resync_cnt_q + 1'b1;
                end
            end
        end
    end

    // fields for the emitter, loaded only with a packet
    always_ff @(posedge clk_i) begin
        if (emit_d) begin
            format_o     <= format_d;
            subformat_o  <= subformat_d;
            with_addr_o  <= with_addr_d;
            branch_o     <= ~(is_branch_i & is_branch_taken_i);  // 0 only if taken
            priv_o       <= priv_i;
            cause_o      <= cause_i;
            interrupt_o  <= interrupt_i;
            addr_o       <= iaddr_i;
            tval_o       <= tval_i;
            branches_o   <= branches_i;
            branch_map_o <= branch_map_i;
        end
    end

    // format 0 is never produced
    a_no_opt_ext: assert property (
        @(posedge clk_i) disable iff (rst_i)
        emit_valid_o |-> (format_o != F_OPT_EXT)
    );

endmodule

/* trdb_branch_map.sv */
module trdb_branch_map (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          add_i,    // current instr is a branch
    input  logic                          taken_i,
    input  logic                          flush_i,  // packet emitted this cycle
    output logic [trdb_pkg::BCNT_LEN-1:0] branches_o,
    output logic [trdb_pkg::BMAP_LEN-1:0] branch_map_o
);

    import trdb_pkg::*;

    logic [BCNT_LEN-1:0] cnt_q;
    logic [BCNT_LEN-1:0] cnt_d;
    logic [BMAP_LEN-1:0] map_q;
    logic [BMAP_LEN-1:0] map_d;

    // next state already holds the current branch
    always_comb begin
        cnt_d = cnt_q;
        map_d = map_q;
        if (add_i && (cnt_q < BCNT_LEN'(BMAP_LEN))) begin
            map_d[cnt_q] = ~taken_i;  // 1 means not taken
            cnt_d        = cnt_q + 1'b1;
        end
    end

    assign branches_o   = cnt_d;
    assign branch_map_o = map_d;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
            map_q <= '0;
        end else if (flush_i) begin
            // branches go out with the packet
            cnt_q <= '0;
            map_q <= '0;
        end else begin
            cnt_q <= cnt_d;
            map_q <= map_d;
        end
    end

    // priority must flush before the map overflows
    a_cnt_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cnt_q < BCNT_LEN'(BMAP_LEN)
    );

endmodule

/* trdb_pkg.sv */
package trdb_pkg;

    // core widths
    localparam int unsigned XLEN      = 32;  // iaddr and tval
    localparam int unsigned PRIV_LEN  = 2;
    localparam int unsigned CAUSE_LEN = 5;

    // branch map
    localparam int unsigned BMAP_LEN = 31;  // max branches held
    localparam int unsigned BCNT_LEN = 5;   // branches field

    // packet sizes
    localparam int unsigned PAYLOAD_LEN = 128;
    localparam int unsigned PLEN_W      = 5;  // payload length in bytes
    localparam int unsigned SEQ_W       = 3;  // header sequence number
    localparam int unsigned HDR_LEN     = SEQ_W + PLEN_W;
    localparam int unsigned PACKET_LEN  = HDR_LEN + PAYLOAD_LEN;

    // forced resync
    localparam int unsigned RESYNC_MAX = 64;
    localparam int unsigned RESYNC_W   = $clog2(RESYNC_MAX);

    // payload bit counts, fields only
    localparam int unsigned START_BITS     = 2 + 2 + 1 + PRIV_LEN + XLEN;
    localparam int unsigned TRAP_BITS      = START_BITS + CAUSE_LEN + 1 + XLEN;
    localparam int unsigned DIFF_BITS      = 2 + BCNT_LEN + BMAP_LEN;  // full map, no addr
    localparam int unsigned DIFF_ADDR_BITS = DIFF_BITS + XLEN;
    localparam int unsigned ADDR_ONLY_BITS = 2 + XLEN + 1;            // + updiscon bit

    // rounded up to whole bytes
    localparam int unsigned START_BYTES     = (START_BITS + 7) / 8;
    localparam int unsigned TRAP_BYTES      = (TRAP_BITS + 7) / 8;
    localparam int unsigned DIFF_BYTES      = (DIFF_BITS + 7) / 8;
    localparam int unsigned DIFF_ADDR_BYTES = (DIFF_ADDR_BITS + 7) / 8;
    localparam int unsigned ADDR_ONLY_BYTES = (ADDR_ONLY_BITS + 7) / 8;

    // packet format, top two payload bits
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,  // not generated here
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } trdb_format_e;

    // subformat of format 3
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,  // unused
        SF_SUPPORT = 2'h3   // unused
    } trdb_f_sync_subformat_e;

endpackage
